/* design/tile_consts.svh */
/* Bus widths, local memory size and address map of the tile fabric.
   Included by the package and by every RTL module that needs a constant. */

`ifndef TILE_CONSTS_SVH
`define TILE_CONSTS_SVH

// AHB-Lite bus widths
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// Local memory size in bytes
`define LMEM_SIZE_BYTE 4096

// Top address nibble of each local region
// Anything else goes out through the external port
`define MAP_NIBBLE_MEM 4'h0
`define MAP_NIBBLE_ROM 4'hF

// Boot image length in words
`define ROM_WORDS 16

`endif

/* design/tile_pkg.sv */
/* Shared AHB-Lite types of the tile fabric and the boot image.
   Modules import it inside their body and use scoped names on ports. */

`default_nettype none

`include "tile_consts.svh"

package tile_pkg;

  typedef logic [`AHB_ADDR_W-1:0] ahb_addr_t;
  typedef logic [`AHB_DATA_W-1:0] ahb_data_t;

  typedef enum logic [1:0] {IDLE, BUSY, NONSEQ, SEQ} htrans_e;
  typedef enum logic [2:0] {BYTE, HALF, WORD} hsize_e;
  typedef enum logic {OKAY, ERROR} hresp_e;

  // Owner of a data phase
  typedef enum logic [1:0] {SLV_MEM, SLV_ROM, SLV_EXT} slave_e;

  // Master to slave, hready is the bus-wide HREADY
  typedef struct packed {
    logic      hsel;
    ahb_addr_t haddr;
    ahb_data_t hwdata;
    logic      hwrite;
    hsize_e    hsize;
    htrans_e   htrans;
    logic      hready;
  } ahb_req_t;

  typedef struct packed {
    ahb_data_t hrdata;
    logic      hready;
    hresp_e    hresp;
  } ahb_rsp_t;

  // Reset stub, clears a few registers, sets the stack and parks
  localparam ahb_data_t boot_image [`ROM_WORDS] = '{
    32'h00000093, 32'h00000113, 32'h00000193, 32'h00000213,
    32'h00000293, 32'h00001137, 32'hffc10113, 32'h00000317,
    32'h00030067, 32'h00000013, 32'h00000013, 32'h00000013,
    32'h00000013, 32'h00000013, 32'h10500073, 32'h0000006f
  };

endpackage

`default_nettype wire

/* design/tile_ahb_decoder.sv */
/* AHB-Lite decoder for the tile. Selects a slave from the top address nibble,
   tracks which slave owns the data phase and returns its response to the host. */

`default_nettype none

`include "tile_consts.svh"

module tile_ahb_decoder (
  input  wire                  clk,
  input  wire                  arst_n_i,
  input  wire tile_pkg::ahb_req_t host_req_i,
  output tile_pkg::ahb_rsp_t   host_rsp_o,
  output tile_pkg::ahb_req_t   mem_req_o,
  output tile_pkg::ahb_req_t   rom_req_o,
  output tile_pkg::ahb_req_t   ext_req_o,
  input  wire tile_pkg::ahb_rsp_t mem_rsp_i,
  input  wire tile_pkg::ahb_rsp_t rom_rsp_i,
  input  wire tile_pkg::ahb_rsp_t ext_rsp_i
);

  import tile_pkg::*;

  slave_e addr_slv;
  slave_e data_slv;
  logic   data_act;
  logic   xfer_valid;
  logic   bus_hready;

  //////////////////////////////////////////////////
  // Address phase

  always_comb begin
    if (host_req_i.haddr[`AHB_ADDR_W-1 -: 4] == `MAP_NIBBLE_MEM) begin
      addr_slv = SLV_MEM;
    end else if (host_req_i.haddr[`AHB_ADDR_W-1 -: 4] == `MAP_NIBBLE_ROM) begin
      addr_slv = SLV_ROM;
    end else begin
      addr_slv = SLV_EXT;
    end
  end

  assign xfer_valid = host_req_i.hsel &&
                      (host_req_i.htrans == NONSEQ || host_req_i.htrans == SEQ);

  // Shared request with a private hsel and the bus HREADY
  function automatic ahb_req_t slave_req(input slave_e slv);
    ahb_req_t req;
    req        = host_req_i;
    req.hsel   = host_req_i.hsel && (addr_slv == slv);
    req.hready = bus_hready;
    return req;
  endfunction

  always_comb begin
    mem_req_o = slave_req(SLV_MEM);
    rom_req_o = slave_req(SLV_ROM);
    ext_req_o = slave_req(SLV_EXT);
  end

  //////////////////////////////////////////////////
  // Data phase

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_act <= 1'b0;
      data_slv <= SLV_MEM;
    end else if (bus_hready) begin
      data_act <= xfer_valid;
      data_slv <= addr_slv;
    end
  end

  // Idle bus answers ready and OKAY
  always_comb begin
    host_rsp_o = '{hrdata: '0, hready: 1'b1, hresp: OKAY};
    if (data_act) begin
      case (data_slv)
        SLV_MEM: host_rsp_o = mem_rsp_i;
        SLV_ROM: host_rsp_o = rom_rsp_i;
        default: host_rsp_o = ext_rsp_i;
      endcase
    end
  end

  assign bus_hready = host_rsp_o.hready;

  a_one_hsel: assert property (@(posedge clk) disable iff (!arst_n_i)
    $onehot0({mem_req_o.hsel, rom_req_o.hsel, ext_req_o.hsel}));

  a_owner_held: assert property (@(posedge clk) disable iff (!arst_n_i)
    (data_act && !bus_hready) |=> (data_act && $stable(data_slv)));

endmodule

`default_nettype wire

/* design/tile_local_mem.sv */
/* Local memory slave of the tile, zero wait states on reads and writes.
   Byte, half and word writes hit only their byte lanes; the address wraps. */

`default_nettype none

`include "tile_consts.svh"

module tile_local_mem (
  input  wire                  clk,
  input  wire                  arst_n_i,
  input  wire tile_pkg::ahb_req_t req_i,
  output tile_pkg::ahb_rsp_t   rsp_o
);

  import tile_pkg::*;

  localparam int LMEM_AW    = $clog2(`LMEM_SIZE_BYTE);
  localparam int LMEM_WORDS = `LMEM_SIZE_BYTE / 4;
  localparam int LANES      = `AHB_DATA_W / 8;
  localparam int OFS_W      = $clog2(LANES);

  ahb_data_t mem [LMEM_WORDS];

  logic               accept;
  logic               dp_act;
  logic [LMEM_AW-1:0] dp_addr;
  hsize_e             dp_size;
  logic               dp_write;
  logic [LMEM_AW-3:0] dp_word;
  logic [LANES-1:0]   wr_mask;

  function automatic logic [LANES-1:0] lane_mask(input hsize_e size,
                                                 input logic [OFS_W-1:0] ofs);
    case (size)
      BYTE:    lane_mask = LANES'(1) << ofs;
      HALF:    lane_mask = LANES'(3) << {ofs[OFS_W-1], 1'b0};
      default: lane_mask = '1;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Address phase capture

  assign accept = req_i.hsel && req_i.hready &&
                  (req_i.htrans == NONSEQ || req_i.htrans == SEQ);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dp_act <= 1'b0;
    end else if (req_i.hready) begin
      dp_act <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dp_addr  <= req_i.haddr[LMEM_AW-1:0];
      dp_size  <= req_i.hsize;
      dp_write <= req_i.hwrite;
    end
  end

  //////////////////////////////////////////////////
  // Data phase

  assign dp_word = dp_addr[LMEM_AW-1:2];
  assign wr_mask = lane_mask(dp_size, dp_addr[OFS_W-1:0]);

  // Write data arrives with the data phase
  always_ff @(posedge clk) begin
    if (dp_act && dp_write) begin
      for (int i = 0; i < LANES; i++) begin
        if (wr_mask[i]) begin
          mem[dp_word][8*i +: 8] <= req_i.hwdata[8*i +: 8];
        end
      end
    end
  end

  assign rsp_o = '{hrdata: mem[dp_word], hready: 1'b1, hresp: OKAY};

endmodule

`default_nettype wire

/* design/tile_boot_rom.sv */
/* Boot ROM slave of the tile. Reads return the boot image word;
   writes get the two-cycle AHB-Lite ERROR response. */

`default_nettype none

`include "tile_consts.svh"

module tile_boot_rom (
  input  wire                  clk,
  input  wire                  arst_n_i,
  input  wire tile_pkg::ahb_req_t req_i,
  output tile_pkg::ahb_rsp_t   rsp_o
);

  import tile_pkg::*;

  localparam int ROM_IDX_W = $clog2(`ROM_WORDS);

  typedef enum logic {ROM_IDLE, ROM_ERR} rom_state_e;

  rom_state_e           state;
  logic                 accept;
  logic                 dp_wr;
  logic [ROM_IDX_W-1:0] dp_idx;

  assign accept = req_i.hsel && req_i.hready &&
                  (req_i.htrans == NONSEQ || req_i.htrans == SEQ);

  // Write data phase pending until its second ERROR cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dp_wr <= 1'b0;
      state <= ROM_IDLE;
    end else begin
      if (req_i.hready) begin
        dp_wr <= accept && req_i.hwrite;
      end
      case (state)
        ROM_IDLE: state <= dp_wr ? ROM_ERR : ROM_IDLE;
        default:  state <= ROM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dp_idx <= req_i.haddr[ROM_IDX_W+1:2];
    end
  end

  // First error cycle stalls, the second one releases the bus
  assign rsp_o = '{hrdata: boot_image[dp_idx],
                   hready: !(dp_wr && state == ROM_IDLE),
                   hresp:  dp_wr ? ERROR : OKAY};

  a_err_two_cycles: assert property (@(posedge clk) disable iff (!arst_n_i)
    (rsp_o.hresp == ERROR && !rsp_o.hready) |=> (rsp_o.hresp == ERROR && rsp_o.hready));

endmodule

`default_nettype wire

/* design/tile_ahb_fabric.sv */
/* Tile AHB-Lite fabric with one host port, local memory and boot ROM.
   Addresses outside the local regions leave through the external port. */

`default_nettype none

`include "tile_consts.svh"

module tile_ahb_fabric (
  input  wire                  clk,
  input  wire                  arst_n_i,
  input  wire tile_pkg::ahb_req_t host_req_i,
  output tile_pkg::ahb_rsp_t   host_rsp_o,
  output tile_pkg::ahb_req_t   ext_req_o,
  input  wire tile_pkg::ahb_rsp_t ext_rsp_i
);

  import tile_pkg::*;

  ahb_req_t mem_req;
  ahb_rsp_t mem_rsp;
  ahb_req_t rom_req;
  ahb_rsp_t rom_rsp;

  //////////////////////////////////////////////////
  // Decoder, external slave sits on ext_req_o

  tile_ahb_decoder u_decoder (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .host_req_i(host_req_i),
    .host_rsp_o(host_rsp_o),
    .mem_req_o (mem_req),
    .rom_req_o (rom_req),
    .ext_req_o (ext_req_o),
    .mem_rsp_i (mem_rsp),
    .rom_rsp_i (rom_rsp),
    .ext_rsp_i (ext_rsp_i)
  );

  //////////////////////////////////////////////////
  // Local slaves

  tile_local_mem u_local_mem (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .req_i   (mem_req),
    .rsp_o   (mem_rsp)
  );

  tile_boot_rom u_boot_rom (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .req_i   (rom_req),
    .rsp_o   (rom_rsp)
  );

endmodule

`default_nettype wire

/* testbench/tile_ahb_fabric_tb.sv */
/* Testbench for the tile AHB-Lite fabric. Drives random pipelined host traffic,
   models the external slave and checks every reply against its own models. */

`default_nettype none

`include "tile_consts.svh"

module tile_ahb_fabric_tb;

  import tile_pkg::*;

  typedef struct packed {
    slave_e    slv;
    logic      write;
    hsize_e    size;
    ahb_addr_t addr;
    ahb_data_t wdata;
  } xfer_t;

  logic        clk = 1'b0;
  logic        arst_n_i;
  ahb_req_t    host_req_i;
  ahb_rsp_t    host_rsp_o;
  ahb_req_t    ext_req_o;
  ahb_rsp_t    ext_rsp_i = '{hrdata: '0, hready: 1'b1, hresp: OKAY};
  logic [15:0] lfsr = 16'd17;
  logic [15:0] ext_lfsr = 16'd17;
  logic [7:0]  lmem_model [`LMEM_SIZE_BYTE];
  ahb_data_t   ext_mem [16];
  logic        ext_act = 1'b0;
  logic        ext_wr = 1'b0;
  logic [3:0]  ext_idx = '0;
  logic [1:0]  ext_wait = '0;
  xfer_t       pending [$];
  int          checks = 0;
  int          errors = 0;
  int          tests = 0;
  logic        timed_out = 1'b0;

  tile_ahb_fabric tile_ahb_fabric_inst (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .host_req_i(host_req_i),
    .host_rsp_o(host_rsp_o),
    .ext_req_o (ext_req_o),
    .ext_rsp_i (ext_rsp_i)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Random numbers from the LFSR x^16 + x^14 + x^13 + x^11 + 1

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic ahb_data_t ext_fill(input logic [3:0] idx);
    return 32'hE5C3_A000 ^ (32'(idx) * 32'h0101_0101);
  endfunction

  //////////////////////////////////////////////////
  // External slave model as a word memory with 0 to 3 wait states

  always @(posedge clk) begin : ext_slave
    logic       ending;
    logic       start;
    logic [1:0] w;
    ending = ext_act && ext_rsp_i.hready;
    start  = ext_req_o.hready && ext_req_o.hsel &&
             (ext_req_o.htrans == NONSEQ || ext_req_o.htrans == SEQ);
    if (!arst_n_i) begin
      for (int i = 0; i < 16; i++) begin
        ext_mem[i] <= ext_fill(4'(i));
      end
      ext_act   <= 1'b0;
      ext_rsp_i <= '{hrdata: '0, hready: 1'b1, hresp: OKAY};
    end else begin
      if (ending && ext_wr) begin
        ext_mem[ext_idx] <= ext_req_o.hwdata;
      end
      if (start) begin
        ext_lfsr = lfsr_step(ext_lfsr);
        w[1]     = ext_lfsr[0];
        ext_lfsr = lfsr_step(ext_lfsr);
        w[0]     = ext_lfsr[0];
        ext_act  <= 1'b1;
        ext_wr   <= ext_req_o.hwrite;
        ext_idx  <= ext_req_o.haddr[5:2];
        ext_wait <= w;
        ext_rsp_i.hready <= (w == 2'd0);
        // Forward a write that completes on this same edge
        if (ending && ext_wr && ext_idx == ext_req_o.haddr[5:2]) begin
          ext_rsp_i.hrdata <= ext_req_o.hwdata;
        end else begin
          ext_rsp_i.hrdata <= ext_mem[ext_req_o.haddr[5:2]];
        end
      end else if (ext_act && !ext_rsp_i.hready) begin
        ext_wait <= ext_wait - 2'd1;
        ext_rsp_i.hready <= (ext_wait == 2'd1);
      end else if (ending) begin
        ext_act <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks

  task automatic check_rdata(input ahb_data_t got, input ahb_data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input ahb_addr_t got, input ahb_addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input hresp_e got, input hresp_e exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Host side models

  function automatic logic lane_hit(input hsize_e size, input logic [1:0] ofs,
                                    input logic [1:0] lane);
    case (size)
      BYTE:    return lane == ofs;
      HALF:    return lane[1] == ofs[1];
      default: return 1'b1;
    endcase
  endfunction

  function automatic ahb_data_t lmem_word(input logic [11:0] a);
    return {lmem_model[{a[11:2], 2'd3}], lmem_model[{a[11:2], 2'd2}],
            lmem_model[{a[11:2], 2'd1}], lmem_model[{a[11:2], 2'd0}]};
  endfunction

  function automatic hsize_e rand_size();
    return hsize_e'(3'(rand_bits(2) % 3));
  endfunction

  // Random upper address bits so local memory wraps
  function automatic xfer_t make_xfer(input slave_e slv, input logic wr, input hsize_e size,
                                      input logic [5:0] ofs);
    xfer_t      x;
    logic [3:0] nib;
    x.slv   = slv;
    x.write = wr;
    x.size  = size;
    x.wdata = rand_bits(32);
    case (slv)
      SLV_MEM: nib = `MAP_NIBBLE_MEM;
      SLV_ROM: nib = `MAP_NIBBLE_ROM;
      default: nib = 4'(rand_bits(4) % 14 + 1);
    endcase
    if (size == HALF) begin
      ofs[0] = 1'b0;
    end
    if (size == WORD) begin
      ofs[1:0] = 2'b00;
    end
    x.addr = {nib, 16'(rand_bits(16)), 6'd0, ofs};
    return x;
  endfunction

  task automatic drive(input xfer_t ap, input logic ap_v, input ahb_data_t wdata);
    host_req_i <= '{hsel: ap_v, haddr: ap.addr, hwdata: wdata, hwrite: ap.write && ap_v,
                    hsize: ap.size, htrans: ap_v ? NONSEQ : IDLE, hready: 1'b1};
  endtask

  task automatic finish_xfer(input xfer_t x, input int stall);
    logic [11:0] a;
    a = x.addr[11:0];
    check_resp(host_rsp_o.hresp, (x.slv == SLV_ROM && x.write) ? ERROR : OKAY, "response");
    case (x.slv)
      SLV_MEM: begin
        check_bit(stall == 0, 1'b1, "local memory wait states");
        if (x.write) begin
          for (int i = 0; i < 4; i++) begin
            if (lane_hit(x.size, a[1:0], 2'(i))) begin
              lmem_model[{a[11:2], 2'(i)}] = x.wdata[8*i +: 8];
            end
          end
        end else begin
          check_rdata(host_rsp_o.hrdata, lmem_word(a), "local memory read");
        end
      end
      SLV_ROM: begin
        check_bit(stall == (x.write ? 1 : 0), 1'b1, "boot ROM wait states");
        if (!x.write) begin
          check_rdata(host_rsp_o.hrdata, boot_image[x.addr[5:2]], "boot ROM read");
        end
      end
      default: begin
        if (x.write) begin
          check_rdata(ext_req_o.hwdata, x.wdata, "external write data");
        end else begin
          check_rdata(host_rsp_o.hrdata, ext_mem[x.addr[5:2]], "external read");
        end
      end
    endcase
  endtask

  // Pipelined host where the address phase of one transfer overlaps the last data phase
  task automatic run_queue();
    xfer_t ap;
    xfer_t dp;
    logic  ap_v;
    logic  dp_v;
    int    stall;
    ap    = '0;
    dp    = '0;
    ap_v  = 1'b0;
    dp_v  = 1'b0;
    stall = 0;
    while (!timed_out && (ap_v || dp_v || pending.size() != 0)) begin
      @(posedge clk);
      if (host_rsp_o.hready) begin
        if (dp_v) begin
          finish_xfer(dp, stall);
        end
        check_bit(ext_req_o.hsel, ap_v && ap.slv == SLV_EXT, "external hsel");
        if (ap_v && ap.slv == SLV_EXT) begin
          check_addr(ext_req_o.haddr, ap.addr, "external address");
          check_bit(ext_req_o.hwrite, ap.write, "external hwrite");
          check_bit(ext_req_o.htrans == NONSEQ && ext_req_o.hsize == ap.size, 1'b1,
                    "external htrans and hsize");
        end
        dp    = ap;
        dp_v  = ap_v;
        stall = 0;
        ap_v  = pending.size() != 0;
        if (ap_v) begin
          ap = pending.pop_front();
        end
        drive(ap, ap_v, dp.wdata);
      end else begin
        check_resp(host_rsp_o.hresp, (dp.slv == SLV_ROM && dp.write) ? ERROR : OKAY,
                   "wait state response");
        stall++;
        if (stall > 16) begin
          $display("Timeout at %0t, HREADY stayed low for more than 16 cycles", $time);
          timed_out = 1'b1;
        end
      end
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before && !timed_out) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests

  task automatic test_reset();
    int e0;
    e0 = errors;
    @(posedge clk);
    check_bit(host_rsp_o.hready, 1'b1, "hready after reset");
    check_resp(host_rsp_o.hresp, OKAY, "response after reset");
    check_bit(ext_req_o.hsel, 1'b0, "external hsel after reset");
    report_test("reset state", e0);
  endtask

  task automatic test_local_mem();
    int e0;
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      pending.push_back(make_xfer(SLV_MEM, 1'b1, WORD, 6'(4 * i)));
    end
    for (int i = 0; i < 24; i++) begin
      pending.push_back(make_xfer(SLV_MEM, 1'b1, rand_size(), 6'(rand_bits(6))));
    end
    for (int i = 0; i < 16; i++) begin
      pending.push_back(make_xfer(SLV_MEM, 1'b0, WORD, 6'(4 * i)));
    end
    run_queue();
    report_test("local memory lanes", e0);
  endtask

  task automatic test_boot_rom();
    int e0;
    e0 = errors;
    for (int i = 0; i < 34; i++) begin
      pending.push_back(make_xfer(SLV_ROM, i == 16 || i == 17, WORD, 6'(4 * (i % 16))));
    end
    run_queue();
    report_test("boot ROM", e0);
  endtask

  task automatic test_external();
    int e0;
    e0 = errors;
    for (int i = 0; i < 40; i++) begin
      pending.push_back(make_xfer(SLV_EXT, i >= 16 && i < 24, WORD, 6'(rand_bits(6))));
    end
    run_queue();
    report_test("external port", e0);
  endtask

  task automatic test_mixed();
    int     e0;
    slave_e slv;
    logic   wr;
    e0 = errors;
    for (int i = 0; i < 80; i++) begin
      slv = slave_e'(2'(rand_bits(2) % 3));
      wr  = 1'(rand_bits(1));
      pending.push_back(make_xfer(slv, wr, (slv == SLV_MEM && wr) ? rand_size() : WORD,
                                  6'(rand_bits(6))));
    end
    run_queue();
    report_test("back-to-back mixed", e0);
  endtask

  initial begin
    arst_n_i   = 1'b0;
    host_req_i = '{hsel: 1'b0, haddr: '0, hwdata: '0, hwrite: 1'b0,
                   hsize: WORD, htrans: IDLE, hready: 1'b1};
    repeat (8) @(posedge clk);
    arst_n_i <= 1'b1;
    test_reset();
    if (!timed_out) begin
      test_local_mem();
    end
    if (!timed_out) begin
      test_boot_rom();
    end
    if (!timed_out) begin
      test_external();
    end
    if (!timed_out) begin
      test_mixed();
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (timed_out || errors != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
design/tile_pkg.sv
design/tile_ahb_decoder.sv
design/tile_local_mem.sv
design/tile_boot_rom.sv
design/tile_ahb_fabric.sv
testbench/tile_ahb_fabric_tb.sv

/* run.sh */
#!/bin/sh
# Build the tile fabric testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f \
  --top-module tile_ahb_fabric_tb -o tile_ahb_fabric_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tile_ahb_fabric_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
